//--- trace_pkg.sv
package trace_pkg;

    // first field of every packet, it sits in bits 3:0
    typedef enum logic [3:0] {
        PKT_BRANCH_MAP = 4'h1,
        PKT_EXCEPTION  = 4'h2,
        PKT_ADDRESS    = 4'h3
    } packet_format_e;

    // longest packet in bits and the width of a length field that can hold it
    localparam int PACKET_LEN   = 48;
    localparam int PACKET_LEN_W = $clog2(PACKET_LEN + 1);

    // output word and its byte lanes
    localparam int BUS_DATA_WIDTH = 32;
    localparam int BUS_BYTES      = BUS_DATA_WIDTH / 8;

    // branch outcomes collected per branch-map packet and the counter width
    localparam int BRANCH_MAP_LEN = 31;
    localparam int MAP_CNT_W      = $clog2(BRANCH_MAP_LEN + 1);

    localparam int CAUSE_LEN = 5;
    localparam int XLEN      = 32;

    localparam int PACKET_FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W        = $clog2(PACKET_FIFO_DEPTH);

    // bit lengths of the three packet kinds, format field included
    localparam logic [PACKET_LEN_W-1:0] BRANCH_PKT_LEN =
        PACKET_LEN_W'(4 + MAP_CNT_W + BRANCH_MAP_LEN);
    localparam logic [PACKET_LEN_W-1:0] EXC_PKT_LEN =
        PACKET_LEN_W'(4 + CAUSE_LEN + XLEN);
    localparam logic [PACKET_LEN_W-1:0] ADDR_PKT_LEN =
        PACKET_LEN_W'(4 + XLEN);

endpackage

//--- trace_packet_emitter.sv
`timescale 1ns/1ps

module trace_packet_emitter (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               retire_valid_i,
    input  logic [trace_pkg::XLEN-1:0]         retire_addr_i,
    input  logic                               branch_i,
    input  logic                               branch_taken_i,
    input  logic                               exception_i,
    input  logic [trace_pkg::CAUSE_LEN-1:0]    cause_i,
    input  logic                               flush_i,
    input  logic                               flush_confirm_i,
    output logic                               pkt_valid_o,
    output logic [trace_pkg::PACKET_LEN-1:0]   pkt_bits_o,
    output logic [trace_pkg::PACKET_LEN_W-1:0] pkt_len_o,
    output logic                               drain_req_o
);

    // orders events that need two packets so that only one push leaves per cycle
    typedef enum logic [1:0] {
        IDLE,
        EXC_PENDING,
        FLUSH_ADDR,
        DRAINING
    } emit_state_e;

    emit_state_e                          state_q, state_d;
    logic [trace_pkg::BRANCH_MAP_LEN-1:0] map_q, map_d;
    logic [trace_pkg::MAP_CNT_W-1:0]      count_q, count_d;
    logic [trace_pkg::XLEN-1:0]           last_addr_q, last_addr_d;
    logic [trace_pkg::XLEN-1:0]           exc_addr_q, exc_addr_d;
    logic [trace_pkg::CAUSE_LEN-1:0]      cause_q, cause_d;
    logic                                 emit_map, emit_exc, emit_addr;
    logic                                 pkt_valid_q, pkt_valid_d;
    logic [trace_pkg::PACKET_LEN-1:0]     pkt_bits_q, pkt_bits_d;
    logic [trace_pkg::PACKET_LEN_W-1:0]   pkt_len_q, pkt_len_d;

    always_comb begin
        state_d     = state_q;
        map_d       = map_q;
        count_d     = count_q;
        last_addr_d = last_addr_q;
        exc_addr_d  = exc_addr_q;
        cause_d     = cause_q;
        emit_map    = 1'b0;
        emit_exc    = 1'b0;
        emit_addr   = 1'b0;

        unique case (state_q)
            IDLE: begin
                // a flush wins over a retirement in the same cycle
                if (flush_i) begin
                    if (count_q != '0) begin
                        emit_map = 1'b1;
                        state_d  = FLUSH_ADDR;
                    end else begin
                        emit_addr = 1'b1;
                        state_d   = DRAINING;
                    end
                end else if (retire_valid_i) begin
                    last_addr_d = retire_addr_i;
                    if (exception_i) begin
                        cause_d    = cause_i;
                        exc_addr_d = retire_addr_i;
                        // a partial map goes out first and the exception follows
                        if (count_q != '0) begin
                            emit_map = 1'b1;
                            state_d  = EXC_PENDING;
                        end else begin
                            emit_exc = 1'b1;
                        end
                    end else if (branch_i) begin
                        map_d[count_q] = branch_taken_i;
                        count_d        = count_q + 1'b1;
                        emit_map       = (count_d == trace_pkg::BRANCH_MAP_LEN);
                    end
                end
            end
            EXC_PENDING: begin
                emit_exc = 1'b1;
                // the map was just emptied so a flush here only needs the address
                state_d  = flush_i ? FLUSH_ADDR : IDLE;
            end
            FLUSH_ADDR: begin
                emit_addr = 1'b1;
                state_d   = DRAINING;
            end
            DRAINING: begin
                if (flush_confirm_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase

        // packet assembly, bits above the packet length stay zero
        pkt_valid_d = emit_map || emit_exc || emit_addr;
        pkt_bits_d  = '0;
        pkt_len_d   = '0;
        if (emit_map) begin
            pkt_bits_d[trace_pkg::BRANCH_PKT_LEN-1:0] =
                {map_d, count_d, trace_pkg::PKT_BRANCH_MAP};
            pkt_len_d = trace_pkg::BRANCH_PKT_LEN;
            map_d     = '0;
            count_d   = '0;
        end else if (emit_exc) begin
            pkt_bits_d[trace_pkg::EXC_PKT_LEN-1:0] =
                {exc_addr_d, cause_d, trace_pkg::PKT_EXCEPTION};
            pkt_len_d = trace_pkg::EXC_PKT_LEN;
        end else if (emit_addr) begin
            pkt_bits_d[trace_pkg::ADDR_PKT_LEN-1:0] = {last_addr_q, trace_pkg::PKT_ADDRESS};
            pkt_len_d = trace_pkg::ADDR_PKT_LEN;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            map_q       <= '0;
            count_q     <= '0;
            last_addr_q <= '0;
            pkt_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            map_q       <= map_d;
            count_q     <= count_d;
            last_addr_q <= last_addr_d;
            pkt_valid_q <= pkt_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        exc_addr_q <= exc_addr_d;
        cause_q    <= cause_d;
        pkt_bits_q <= pkt_bits_d;
        pkt_len_q  <= pkt_len_d;
    end

    assign pkt_valid_o = pkt_valid_q;
    assign pkt_bits_o  = pkt_bits_q;
    assign pkt_len_o   = pkt_len_q;

    // held back while the address packet is still being pushed
    // so the aligner only sees the request once that packet is visible at the fifo head
    assign drain_req_o = (state_q == DRAINING) && !pkt_valid_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pkt_valid_o |-> (pkt_len_o <= trace_pkg::PACKET_LEN));

endmodule

//--- trace_packet_fifo.sv
`timescale 1ns/1ps

module trace_packet_fifo (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               push_i,
    input  logic [trace_pkg::PACKET_LEN-1:0]   push_bits_i,
    input  logic [trace_pkg::PACKET_LEN_W-1:0] push_len_i,
    input  logic                               pop_i,
    output logic                               head_valid_o,
    output logic [trace_pkg::PACKET_LEN-1:0]   head_bits_o,
    output logic [trace_pkg::PACKET_LEN_W-1:0] head_len_o,
    output logic                               full_o,
    output logic                               overflow_o
);

    logic [trace_pkg::PACKET_LEN-1:0]   bits_mem [trace_pkg::PACKET_FIFO_DEPTH];
    logic [trace_pkg::PACKET_LEN_W-1:0] len_mem  [trace_pkg::PACKET_FIFO_DEPTH];
    logic [trace_pkg::FIFO_PTR_W-1:0]   wr_ptr_q, rd_ptr_q;
    logic [trace_pkg::FIFO_PTR_W:0]     count_q;
    logic                               overflow_q;
    logic                               push_ok, pop_ok;

    assign head_valid_o = (count_q != '0);
    assign full_o       = (count_q == trace_pkg::PACKET_FIFO_DEPTH);
    assign head_bits_o  = bits_mem[rd_ptr_q];
    assign head_len_o   = len_mem[rd_ptr_q];
    assign overflow_o   = overflow_q;

    // a push into a full queue is lost even if a pop happens in the same cycle
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && head_valid_o;

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            bits_mem[wr_ptr_q] <= push_bits_i;
            len_mem[wr_ptr_q]  <= push_len_i;
        end
    end

    // the depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            unique case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // sticky until the next reset
            if (push_i && full_o) begin
                overflow_q <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> head_valid_o);

endmodule

//--- trace_byte_aligner.sv
`timescale 1ns/1ps

module trace_byte_aligner (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  logic [trace_pkg::PACKET_LEN-1:0]     payload_bits_i,
    input  logic [trace_pkg::PACKET_LEN_W-1:0]   payload_len_i,
    input  logic                                 valid_i,
    input  logic                                 drain_req_i,
    output logic                                 grant_o,
    output logic                                 flush_confirm_o,
    output logic [trace_pkg::BUS_DATA_WIDTH-1:0] data_o,
    output logic                                 valid_o,
    output logic                                 flush_done_o
);

    // stream image of the head packet with the header byte in the lowest byte
    logic [trace_pkg::PACKET_LEN+7:0]     image;
    // byte counts where an image is never longer than seven bytes
    logic [2:0]                           payload_bytes, image_bytes;
    logic [2:0]                           ptr_q, ptr_d;
    logic [2:0]                           avail, room, take, total;
    logic [1:0]                           res_cnt_q, res_cnt_d;
    logic [trace_pkg::BUS_DATA_WIDTH-1:0] res_q, res_d, word;
    logic [trace_pkg::BUS_DATA_WIDTH-1:0] data_q, data_d;
    logic                                 valid_q, valid_d, done_q, done_d;

    // ceiling of the bit length over eight
    assign payload_bytes = payload_len_i[5:3] + {2'b00, |payload_len_i[2:0]};
    assign image_bytes   = payload_bytes + 3'd1;
    assign image         = {payload_bits_i, 5'b00000, payload_bytes};

    // the residual leaves this much room in the current word
    assign avail = image_bytes - ptr_q;
    assign room  = 3'(trace_pkg::BUS_BYTES) - {1'b0, res_cnt_q};
    assign take  = !valid_i ? 3'd0 : ((avail < room) ? avail : room);
    assign total = {1'b0, res_cnt_q} + take;

    // residual bytes stay in the low lanes and new bytes land right above them
    always_comb begin : merge_bytes
        int src;
        word = res_q;
        for (int i = 0; i < trace_pkg::BUS_BYTES; i++) begin
            src = int'(ptr_q) + i - int'(res_cnt_q);
            if (i >= int'(res_cnt_q) && i < int'(total)) begin
                word[i*8 +: 8] = image[src*8 +: 8];
            end
        end
    end

    always_comb begin
        ptr_d           = ptr_q;
        res_d           = res_q;
        res_cnt_d       = res_cnt_q;
        data_d          = word;
        valid_d         = 1'b0;
        done_d          = 1'b0;
        grant_o         = 1'b0;
        flush_confirm_o = 1'b0;

        if (valid_i) begin
            if (total == 3'(trace_pkg::BUS_BYTES)) begin
                valid_d   = 1'b1;
                res_d     = '0;
                res_cnt_d = '0;
            end else begin
                // lanes above total are still zero so the word doubles as the residual
                res_d     = word;
                res_cnt_d = total[1:0];
            end
            // last byte of the image taken so the fifo may pop
            if (take == avail) begin
                grant_o = 1'b1;
                ptr_d   = '0;
            end else begin
                ptr_d = ptr_q + take;
            end
        end else if (drain_req_i) begin
            // fifo is empty and no packet is half taken
            flush_confirm_o = 1'b1;
            done_d          = 1'b1;
            if (res_cnt_q != '0) begin
                data_d    = res_q;
                valid_d   = 1'b1;
                res_d     = '0;
                res_cnt_d = '0;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q     <= '0;
            res_q     <= '0;
            res_cnt_q <= '0;
            valid_q   <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            ptr_q     <= ptr_d;
            res_q     <= res_d;
            res_cnt_q <= res_cnt_d;
            valid_q   <= valid_d;
            done_q    <= done_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_d) begin
            data_q <= data_d;
        end
    end

    assign data_o       = data_q;
    assign valid_o      = valid_q;
    assign flush_done_o = done_q;

    // the zero-filled last word only comes out of a drain with no packet half taken
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (valid_o && flush_done_o) |-> $past(drain_req_i && (ptr_q == '0)));

    // a packet that is partly taken keeps the fifo head valid up to and including its grant
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((ptr_q != '0) || grant_o) |-> valid_i);

endmodule

//--- trace_encoder_top.sv
`timescale 1ns/1ps

module trace_encoder_top (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              retire_valid_i,
    input  logic [trace_pkg::XLEN-1:0]        retire_addr_i,
    input  logic                              branch_i,
    input  logic                              branch_taken_i,
    input  logic                              exception_i,
    input  logic [trace_pkg::CAUSE_LEN-1:0]   cause_i,
    input  logic                              flush_i,
    output logic [trace_pkg::BUS_BYTES*8-1:0] data_o,
    output logic                              valid_o,
    output logic                              flush_done_o,
    output logic                              overflow_o
);

    logic                               pkt_valid;
    logic [trace_pkg::PACKET_LEN-1:0]   pkt_bits;
    logic [trace_pkg::PACKET_LEN_W-1:0] pkt_len;
    logic                               head_valid;
    logic [trace_pkg::PACKET_LEN-1:0]   head_bits;
    logic [trace_pkg::PACKET_LEN_W-1:0] head_len;
    logic                               grant;
    logic                               drain_req;
    logic                               flush_confirm;

    trace_packet_emitter trace_packet_emitter_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .retire_valid_i  (retire_valid_i),
        .retire_addr_i   (retire_addr_i),
        .branch_i        (branch_i),
        .branch_taken_i  (branch_taken_i),
        .exception_i     (exception_i),
        .cause_i         (cause_i),
        .flush_i         (flush_i),
        .flush_confirm_i (flush_confirm),
        .pkt_valid_o     (pkt_valid),
        .pkt_bits_o      (pkt_bits),
        .pkt_len_o       (pkt_len),
        .drain_req_o     (drain_req)
    );

    // the emitter never waits on a full queue, losses show up on overflow_o
    trace_packet_fifo trace_packet_fifo_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (pkt_valid),
        .push_bits_i  (pkt_bits),
        .push_len_i   (pkt_len),
        .pop_i        (grant),
        .head_valid_o (head_valid),
        .head_bits_o  (head_bits),
        .head_len_o   (head_len),
        .full_o       (),
        .overflow_o   (overflow_o)
    );

    trace_byte_aligner trace_byte_aligner_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .payload_bits_i  (head_bits),
        .payload_len_i   (head_len),
        .valid_i         (head_valid),
        .drain_req_i     (drain_req),
        .grant_o         (grant),
        .flush_confirm_o (flush_confirm),
        .data_o          (data_o),
        .valid_o         (valid_o),
        .flush_done_o    (flush_done_o)
    );

endmodule

//--- tb_trace_encoder.sv
`timescale 1ns/1ps

module tb_trace_encoder;

    logic                                 clk_i = 1'b0;
    logic                                 rst_ni;
    logic                                 retire_valid_i;
    logic [trace_pkg::XLEN-1:0]           retire_addr_i;
    logic                                 branch_i;
    logic                                 branch_taken_i;
    logic                                 exception_i;
    logic [trace_pkg::CAUSE_LEN-1:0]      cause_i;
    logic                                 flush_i;
    logic [trace_pkg::BUS_DATA_WIDTH-1:0] data_o;
    logic                                 valid_o;
    logic                                 flush_done_o;
    logic                                 overflow_o;

    // reference stream bytes in output order, and the word they should form next
    logic [7:0]                           exp_bytes [$];
    logic [trace_pkg::BUS_DATA_WIDTH-1:0] exp_word;
    int                                   exp_avail;
    // reference copy of the branch map the emitter is filling
    logic [trace_pkg::BRANCH_MAP_LEN-1:0] ref_map;
    int                                   ref_count;
    logic [trace_pkg::XLEN-1:0]           ref_last_addr;
    logic                                 checking;
    logic                                 idle_phase;

    trace_encoder_top trace_encoder_top_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .retire_valid_i (retire_valid_i),
        .retire_addr_i  (retire_addr_i),
        .branch_i       (branch_i),
        .branch_taken_i (branch_taken_i),
        .exception_i    (exception_i),
        .cause_i        (cause_i),
        .flush_i        (flush_i),
        .data_o         (data_o),
        .valid_o        (valid_o),
        .flush_done_o   (flush_done_o),
        .overflow_o     (overflow_o)
    );

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    // next word is the first four queued bytes, lanes past the end read as zero
    function automatic void refresh_expected();
        exp_word = '0;
        for (int i = 0; i < trace_pkg::BUS_BYTES; i++) begin
            if (i < exp_bytes.size()) begin
                exp_word[i*8 +: 8] = exp_bytes[i];
            end
        end
        exp_avail = exp_bytes.size();
    endfunction

    // header byte holds the byte count, then the packet bytes go out LSB first
    function automatic void push_packet(input logic [63:0] bits, input int len);
        int nbytes;
        nbytes = (len + 7) / 8;
        exp_bytes.push_back(8'(nbytes));
        for (int i = 0; i < nbytes; i++) begin
            exp_bytes.push_back(bits[i*8 +: 8]);
        end
        refresh_expected();
    endfunction

    // branch map is format, count in 8:4 and map in 39:9, forty bits in all
    function automatic void emit_branch_map();
        logic [63:0] pkt;
        pkt        = '0;
        pkt[3:0]   = trace_pkg::PKT_BRANCH_MAP;
        pkt[8:4]   = 5'(ref_count);
        pkt[39:9]  = ref_map;
        push_packet(pkt, 40);
        ref_map   = '0;
        ref_count = 0;
    endfunction

    task automatic clear_inputs();
        retire_valid_i = 1'b0;
        branch_i       = 1'b0;
        branch_taken_i = 1'b0;
        exception_i    = 1'b0;
        cause_i        = '0;
        flush_i        = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk_i);
            clear_inputs();
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // one retirement for a single cycle, the reference model follows the packet rules
    task automatic retire_one(input logic br, input logic exc);
        logic [trace_pkg::XLEN-1:0]      addr;
        logic [trace_pkg::CAUSE_LEN-1:0] cause;
        logic                            taken;
        logic [63:0]                     pkt;
        addr  = $urandom();
        cause = 5'($urandom());
        taken = 1'($urandom_range(0, 1));
        @(negedge clk_i);
        clear_inputs();
        retire_valid_i = 1'b1;
        retire_addr_i  = addr;
        branch_i       = br;
        branch_taken_i = taken;
        exception_i    = exc;
        cause_i        = cause;
        ref_last_addr  = addr;
        if (exc) begin
            // a partial map is closed before the exception packet
            if (ref_count != 0) begin
                emit_branch_map();
            end
            pkt       = '0;
            pkt[3:0]  = trace_pkg::PKT_EXCEPTION;
            pkt[8:4]  = cause;
            pkt[40:9] = addr;
            push_packet(pkt, 41);
        end else if (br) begin
            ref_map[ref_count] = taken;
            ref_count++;
            if (ref_count == trace_pkg::BRANCH_MAP_LEN) begin
                emit_branch_map();
            end
        end
    endtask

    // flush closes any map, adds the address packet and waits for the done pulse
    task automatic flush_stream();
        logic [63:0] pkt;
        int          waited;
        @(negedge clk_i);
        clear_inputs();
        flush_i = 1'b1;
        if (ref_count != 0) begin
            emit_branch_map();
        end
        pkt       = '0;
        pkt[3:0]  = trace_pkg::PKT_ADDRESS;
        pkt[35:4] = ref_last_addr;
        push_packet(pkt, 36);
        @(negedge clk_i);
        flush_i = 1'b0;
        waited  = 0;
        while (!flush_done_o) begin
            if (waited == 200) begin
                fail_timeout("flush_done_o after a flush request");
            end
            @(negedge clk_i);
            waited++;
        end
    endtask

    // reset starts at the calling negedge, outputs must stay quiet a while after it
    task automatic apply_reset();
        rst_ni     = 1'b0;
        idle_phase = 1'b1;
        clear_inputs();
        retire_addr_i = '0;
        ref_map       = '0;
        ref_count     = 0;
        ref_last_addr = '0;
        exp_bytes.delete();
        refresh_expected();
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;
        repeat (4) @(negedge clk_i);
        idle_phase = 1'b0;
    endtask

    // words leave the queue at the edge where the assertions already sampled them
    always @(posedge clk_i) begin
        if (rst_ni && checking && valid_o) begin
            for (int i = 0; i < trace_pkg::BUS_BYTES; i++) begin
                if (exp_bytes.size() > 0) begin
                    void'(exp_bytes.pop_front());
                end
            end
            refresh_expected();
        end
    end

    word_matches: assert property (@(posedge clk_i) disable iff (!rst_ni || !checking)
        valid_o |-> (data_o == exp_word))
    else begin
        $display("ERROR t=%0t data_o expected %08h actual %08h",
                 $time, $sampled(exp_word), $sampled(data_o));
        $display(">>> FAIL");
        $fatal(1);
    end

    // a full word only once four bytes are due, the last flush word holds one to three
    full_word_only: assert property (@(posedge clk_i) disable iff (!rst_ni || !checking)
        (valid_o && !flush_done_o) |-> (exp_avail >= trace_pkg::BUS_BYTES))
    else begin
        $display("a word came out before four stream bytes were due");
        $display(">>> FAIL");
        $fatal(1);
    end

    last_word_partial: assert property (@(posedge clk_i) disable iff (!rst_ni || !checking)
        (valid_o && flush_done_o) |-> (exp_avail > 0 && exp_avail < trace_pkg::BUS_BYTES))
    else begin
        $display("the closing word of a flush did not carry the leftover bytes");
        $display(">>> FAIL");
        $fatal(1);
    end

    drained_on_done: assert property (@(posedge clk_i) disable iff (!rst_ni || !checking)
        (flush_done_o && !valid_o) |-> (exp_avail == 0))
    else begin
        $display("a flush finished while stream bytes were still missing");
        $display(">>> FAIL");
        $fatal(1);
    end

    overflow_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
        overflow_o |=> overflow_o)
    else begin
        $display("overflow_o dropped before a reset");
        $display(">>> FAIL");
        $fatal(1);
    end

    quiet_after_reset: assert property (@(posedge clk_i)
        idle_phase |-> (!valid_o && !flush_done_o && !overflow_o))
    else begin
        $display("an output was active during or right after reset");
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin
        int pick;
        int waited;
        void'($urandom(32'h4659));
        checking = 1'b1;
        apply_reset();

        // a full map of thirty-one outcomes
        repeat (trace_pkg::BRANCH_MAP_LEN) retire_one(1'b1, 1'b0);
        idle_cycles(4);
        // a partial map closed by an exception
        repeat (7) retire_one(1'b1, 1'b0);
        retire_one(1'b0, 1'b1);
        idle_cycles(3);
        flush_stream();

        // random mix, paced so the queue never fills, each round ends in a flush
        for (int round = 0; round < 12; round++) begin
            for (int step = 0; step < 50; step++) begin
                pick = $urandom_range(0, 9);
                if (pick < 6) begin
                    retire_one(1'b1, 1'b0);
                end else if (pick < 8) begin
                    retire_one(1'b0, 1'b0);
                end else if (pick == 8) begin
                    retire_one(1'b0, 1'b1);
                    idle_cycles(3);
                end else begin
                    idle_cycles(1);
                end
            end
            flush_stream();
        end

        // back-to-back exceptions outrun the aligner and the queue overflows
        checking = 1'b0;
        waited   = 0;
        while (!overflow_o) begin
            if (waited == 64) begin
                fail_timeout("overflow_o under back-to-back exceptions");
            end
            retire_one(1'b0, 1'b1);
            waited++;
        end
        idle_cycles(20);
        apply_reset();
        idle_cycles(4);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- trace_encoder_top.f
trace_pkg.sv
trace_packet_emitter.sv
trace_packet_fifo.sv
trace_byte_aligner.sv
trace_encoder_top.sv
tb_trace_encoder.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_trace_encoder
FILELIST  ?= trace_encoder_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
